// ==== src/loader_pkg.sv ====
// Memory loader shared definitions
// Widths, the peer memory request record, download kinds and loader states
// used by the memory-loading path of the home-computer top level

package loader_pkg;

	// One byte of the shared memory
	typedef logic [7:0] byte_t;

	// Shared memory address, low 64 KB is computer RAM, upper half holds tape images
	typedef logic [17:0] addr_t;

	// Address as seen by the computer core
	typedef logic [15:0] c64_addr_t;

	// Memory request from any peer, held until granted
	typedef struct packed {
		logic  req;
		logic  we;
		addr_t addr;
		byte_t data;
	} mem_req_t;

	// Host download index
	typedef enum logic [7:0] {
		DL_OTHER = 8'd0,
		DL_PRG   = 8'd4,
		DL_TAP   = 8'd6
	} dl_kind_e;

	// PRG loader FSM
	typedef enum logic [1:0] {
		PRG_IDLE,
		PRG_HDR,
		PRG_DATA,
		PRG_PTRS
	} prg_state_e;

	localparam addr_t     TAP_BASE_DEF = 18'h20000;
	localparam c64_addr_t PTR_END_ADDR = 16'h0100;

endpackage

// ==== src/byte_ram.sv ====
// Byte RAM
// Single-port synchronous byte memory covering the whole shared address
// space, written on the clock edge and read back one cycle later

`timescale 1ns/100ps

module byte_ram (
	input  logic               clk_sys,
	input  logic               we_i,
	input  loader_pkg::addr_t  addr_i,
	input  loader_pkg::byte_t  wdata_i,
	output loader_pkg::byte_t  rdata_o
);

	import loader_pkg::*;

	localparam int DEPTH = 1 << $bits(addr_t);

	byte_t mem [0:DEPTH-1];

	// Registered read on every clock, old data when written in the same cycle
	always_ff @(posedge clk_sys) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
		rdata_o <= mem[addr_i];
	end

endmodule

// ==== src/mem_arbiter.sv ====
// Memory arbiter
// Fixed-priority sharing of the byte RAM: core first, then PRG loader,
// then tape reader. Grants are combinational, read data follows one cycle
// later with a strobe to the peer that asked for it

`timescale 1ns/100ps

module mem_arbiter (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  loader_pkg::mem_req_t  core_req_i,
	input  loader_pkg::mem_req_t  load_req_i,
	input  loader_pkg::mem_req_t  tape_req_i,
	output logic                  core_gnt_o,
	output logic                  load_gnt_o,
	output logic                  tape_gnt_o,
	output logic                  core_rvalid_o,
	output logic                  tape_rvalid_o,
	output loader_pkg::byte_t     rdata_o
);

	import loader_pkg::*;

	mem_req_t sel;

	assign core_gnt_o = core_req_i.req;
	assign load_gnt_o = load_req_i.req & ~core_req_i.req;
	assign tape_gnt_o = tape_req_i.req & ~core_req_i.req & ~load_req_i.req;

	// Winner drives the RAM
	always_comb begin
		if (core_req_i.req) begin
			sel = core_req_i;
		end else if (load_req_i.req) begin
			sel = load_req_i;
		end else begin
			sel = tape_req_i;
		end
	end

	byte_ram byte_ram_i (
		.clk_sys (clk_sys),
		.we_i    (sel.req & sel.we),
		.addr_i  (sel.addr),
		.wdata_i (sel.data),
		.rdata_o (rdata_o)
	);

	// Remember who read so the returned byte is flagged to that peer
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			core_rvalid_o <= 1'b0;
			tape_rvalid_o <= 1'b0;
		end else begin
			core_rvalid_o <= core_gnt_o & ~core_req_i.we;
			tape_rvalid_o <= tape_gnt_o & ~tape_req_i.we;
		end
	end

endmodule

// ==== src/prg_loader.sv ====
// PRG loader
// Writes a PRG download into computer RAM at the address given by its
// two header bytes, then sets the BASIC start and end pointers in the
// zero page and pulses load_done_o

`timescale 1ns/100ps

module prg_loader (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  dl_active_i,
	input  loader_pkg::dl_kind_e  dl_kind_i,
	input  logic                  dl_wr_i,
	input  loader_pkg::addr_t     dl_addr_i,
	input  loader_pkg::byte_t     dl_data_i,
	output loader_pkg::mem_req_t  mem_req_o,
	input  logic                  mem_gnt_i,
	output logic                  pending_o,
	output logic                  load_done_o
);

	import loader_pkg::*;

	prg_state_e state;
	mem_req_t   req_q;
	logic       active_q;
	c64_addr_t  load_addr;
	c64_addr_t  start_addr;
	c64_addr_t  end_addr;
	c64_addr_t  sweep_addr;
	logic       ptr_hit;
	byte_t      ptr_data;

	logic prg_dl;
	logic prg_wr;
	logic prg_end;

	assign prg_dl  = dl_active_i && (dl_kind_i == DL_PRG);
	assign prg_wr  = prg_dl && dl_wr_i;
	assign prg_end = active_q && !dl_active_i && (dl_kind_i == DL_PRG);

	assign mem_req_o = req_q;
	assign pending_o = req_q.req;

	// Zero-page pointers: TXT/SAVE_START get the start, VAR/ARY/STR/LOAD_END the end
	always_comb begin
		ptr_hit  = 1'b1;
		ptr_data = start_addr[7:0];
		case (sweep_addr)
			16'h002B, 16'h00AC:                 ptr_data = start_addr[7:0];
			16'h002C, 16'h00AD:                 ptr_data = start_addr[15:8];
			16'h002D, 16'h002F, 16'h0031, 16'h00AE: ptr_data = end_addr[7:0];
			16'h002E, 16'h0030, 16'h0032, 16'h00AF: ptr_data = end_addr[15:8];
			default:                            ptr_hit  = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state       <= PRG_IDLE;
			req_q       <= '0;
			active_q    <= 1'b0;
			load_done_o <= 1'b0;
		end else begin
			active_q    <= dl_active_i;
			load_done_o <= 1'b0;
			if (mem_gnt_i) begin
				req_q.req <= 1'b0;
			end

			case (state)
				// ============================================================
				// Header: two bytes of load address
				// ============================================================
				PRG_IDLE, PRG_HDR: begin
					if (prg_dl) state <= PRG_HDR;
					if (prg_wr && dl_addr_i == addr_t'(0)) begin
						load_addr[7:0]  <= dl_data_i;
						start_addr[7:0] <= dl_data_i;
						end_addr[7:0]   <= dl_data_i;
					end
					if (prg_wr && dl_addr_i == addr_t'(1)) begin
						load_addr[15:8]  <= dl_data_i;
						start_addr[15:8] <= dl_data_i;
						end_addr[15:8]   <= dl_data_i;
						state            <= PRG_DATA;
					end
					if (prg_end) state <= PRG_IDLE;
				end
				// ============================================================
				// Payload bytes, one write per strobe
				// ============================================================
				PRG_DATA: begin
					if (prg_wr) begin
						req_q     <= '{req: 1'b1, we: 1'b1, addr: addr_t'(load_addr),
						               data: dl_data_i};
						load_addr <= load_addr + 16'd1;
						end_addr  <= end_addr + 16'd1;
					end
					if (prg_end) begin
						sweep_addr <= '0;
						state      <= PRG_PTRS;
					end
				end
				// ============================================================
				// Zero-page sweep, waits for each write before moving on
				// ============================================================
				PRG_PTRS: begin
					if (!req_q.req) begin
						if (sweep_addr == PTR_END_ADDR) begin
							load_done_o <= 1'b1;
							state       <= PRG_IDLE;
						end else begin
							if (ptr_hit) begin
								req_q <= '{req: 1'b1, we: 1'b1, addr: addr_t'(sweep_addr),
								           data: ptr_data};
							end
							sweep_addr <= sweep_addr + 16'd1;
						end
					end
				end
				default: state <= PRG_IDLE;
			endcase
		end
	end

endmodule

// ==== src/tape_reader.sv ====
// Tape reader
// Stores a TAP download at TAP_BASE and plays it back one byte at a time
// toward the cassette consumer, honouring its full flag

`timescale 1ns/100ps

module tape_reader #(
	parameter loader_pkg::addr_t TAP_BASE = loader_pkg::TAP_BASE_DEF
) (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  dl_active_i,
	input  loader_pkg::dl_kind_e  dl_kind_i,
	input  logic                  dl_wr_i,
	input  loader_pkg::addr_t     dl_addr_i,
	input  loader_pkg::byte_t     dl_data_i,
	input  logic                  tape_play_i,
	input  logic                  tape_full_i,
	output loader_pkg::mem_req_t  mem_req_o,
	input  logic                  mem_gnt_i,
	input  logic                  mem_rvalid_i,
	input  loader_pkg::byte_t     mem_rdata_i,
	output logic                  pending_o,
	output loader_pkg::byte_t     tape_data_o,
	output logic                  tape_valid_o,
	output logic                  tape_end_o
);

	import loader_pkg::*;

	mem_req_t req_q;
	logic     active_q;
	logic     rd_busy;
	addr_t    play_addr;
	addr_t    tap_len;
	addr_t    dl_len;

	logic tap_dl;
	logic tap_start;
	logic tap_done;
	logic rd_ok;

	assign tap_dl    = dl_active_i && (dl_kind_i == DL_TAP);
	assign tap_start = tap_dl && !active_q;
	assign tap_done  = active_q && !dl_active_i && (dl_kind_i == DL_TAP);
	assign rd_ok     = tape_play_i && !tape_full_i && !req_q.req && !rd_busy &&
	                   !tap_dl && (play_addr != tap_len);

	assign mem_req_o = req_q;
	// Only download writes hold off the host
	assign pending_o = req_q.req & req_q.we;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			req_q        <= '0;
			active_q     <= 1'b0;
			rd_busy      <= 1'b0;
			play_addr    <= '0;
			tap_len      <= '0;
			tape_valid_o <= 1'b0;
			tape_end_o   <= 1'b0;
		end else begin
			active_q     <= dl_active_i;
			tape_valid_o <= 1'b0;
			tape_end_o   <= (tap_len != '0) && (play_addr == tap_len) && !rd_busy;

			if (mem_gnt_i) begin
				req_q.req <= 1'b0;
				if (!req_q.we) begin
					rd_busy   <= 1'b1;
					play_addr <= play_addr + addr_t'(1);
				end
			end
			if (mem_rvalid_i && rd_busy) begin
				tape_data_o  <= mem_rdata_i;
				tape_valid_o <= 1'b1;
				rd_busy      <= 1'b0;
			end

			// New tape download restarts playback from the beginning
			if (tap_start) begin
				play_addr <= '0;
				tap_len   <= '0;
				dl_len    <= '0;
				rd_busy   <= 1'b0;
				req_q.req <= 1'b0;
			end else if (tap_dl && dl_wr_i) begin
				req_q  <= '{req: 1'b1, we: 1'b1, addr: TAP_BASE + dl_addr_i, data: dl_data_i};
				dl_len <= dl_addr_i + addr_t'(1);
			end else if (tap_done) begin
				tap_len <= dl_len;
			end else if (rd_ok) begin
				req_q <= '{req: 1'b1, we: 1'b0, addr: TAP_BASE + play_addr, data: '0};
			end
		end
	end

endmodule

// ==== src/c64_loader_top.sv ====
// Loader top level
// Connects the PRG loader, the tape reader and the core port to one byte
// RAM through the fixed-priority arbiter

`timescale 1ns/100ps

module c64_loader_top #(
	parameter loader_pkg::addr_t TAP_BASE = loader_pkg::TAP_BASE_DEF
) (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	// Host download bus
	input  logic                  dl_active_i,
	input  loader_pkg::dl_kind_e  dl_kind_i,
	input  logic                  dl_wr_i,
	input  loader_pkg::addr_t     dl_addr_i,
	input  loader_pkg::byte_t     dl_data_i,
	output logic                  dl_wait_o,
	// Computer core memory port
	input  loader_pkg::mem_req_t  core_req_i,
	output logic                  core_gnt_o,
	output loader_pkg::byte_t     core_rdata_o,
	output logic                  core_rvalid_o,
	// Cassette side
	input  logic                  tape_play_i,
	input  logic                  tape_full_i,
	output loader_pkg::byte_t     tape_data_o,
	output logic                  tape_valid_o,
	output logic                  tape_end_o,
	output logic                  load_done_o
);

	import loader_pkg::*;

	mem_req_t load_req;
	mem_req_t tape_req;
	logic     load_gnt;
	logic     tape_gnt;
	logic     tape_rvalid;
	logic     load_pending;
	logic     tape_pending;
	byte_t    mem_rdata;

	assign dl_wait_o    = load_pending | tape_pending;
	assign core_rdata_o = mem_rdata;

	prg_loader prg_loader_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_kind_i   (dl_kind_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.mem_req_o   (load_req),
		.mem_gnt_i   (load_gnt),
		.pending_o   (load_pending),
		.load_done_o (load_done_o)
	);

	tape_reader #(
		.TAP_BASE (TAP_BASE)
	) tape_reader_i (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.dl_active_i  (dl_active_i),
		.dl_kind_i    (dl_kind_i),
		.dl_wr_i      (dl_wr_i),
		.dl_addr_i    (dl_addr_i),
		.dl_data_i    (dl_data_i),
		.tape_play_i  (tape_play_i),
		.tape_full_i  (tape_full_i),
		.mem_req_o    (tape_req),
		.mem_gnt_i    (tape_gnt),
		.mem_rvalid_i (tape_rvalid),
		.mem_rdata_i  (mem_rdata),
		.pending_o    (tape_pending),
		.tape_data_o  (tape_data_o),
		.tape_valid_o (tape_valid_o),
		.tape_end_o   (tape_end_o)
	);

	mem_arbiter mem_arbiter_i (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.core_req_i    (core_req_i),
		.load_req_i    (load_req),
		.tape_req_i    (tape_req),
		.core_gnt_o    (core_gnt_o),
		.load_gnt_o    (load_gnt),
		.tape_gnt_o    (tape_gnt),
		.core_rvalid_o (core_rvalid_o),
		.tape_rvalid_o (tape_rvalid),
		.rdata_o       (mem_rdata)
	);

endmodule

// ==== tests/tb_c64_loader.sv ====
// Loader testbench
// Replays the command list from the test data file against the loader top
// level: core accesses, PRG and TAP downloads, tape playback under random
// back-pressure, with checks of read data, BASIC pointers and tape bytes

`timescale 1ns/100ps

module tb_c64_loader;

	import loader_pkg::*;

	localparam int MAX_CMDS = 128;
	localparam int TIMEOUT  = 2000;

	logic     clk_sys;
	logic     reset_n;
	logic     dl_active_i;
	dl_kind_e dl_kind_i;
	logic     dl_wr_i;
	addr_t    dl_addr_i;
	byte_t    dl_data_i;
	logic     dl_wait_o;
	mem_req_t core_req_i;
	logic     core_gnt_o;
	byte_t    core_rdata_o;
	logic     core_rvalid_o;
	logic     tape_play_i;
	logic     tape_full_i;
	byte_t    tape_data_o;
	logic     tape_valid_o;
	logic     tape_end_o;
	logic     load_done_o;

	logic [31:0] cmds [0:MAX_CMDS-1];
	byte_t       expected_tape [$];
	byte_t       tape_byte;
	integer      seed = 32'hd199;
	logic        done_seen = 1'b0;
	logic        dl_open = 1'b0;
	dl_kind_e    open_kind = DL_OTHER;
	int          fail_count = 0;

	c64_loader_top c64_loader_top_i (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.dl_active_i   (dl_active_i),
		.dl_kind_i     (dl_kind_i),
		.dl_wr_i       (dl_wr_i),
		.dl_addr_i     (dl_addr_i),
		.dl_data_i     (dl_data_i),
		.dl_wait_o     (dl_wait_o),
		.core_req_i    (core_req_i),
		.core_gnt_o    (core_gnt_o),
		.core_rdata_o  (core_rdata_o),
		.core_rvalid_o (core_rvalid_o),
		.tape_play_i   (tape_play_i),
		.tape_full_i   (tape_full_i),
		.tape_data_o   (tape_data_o),
		.tape_valid_o  (tape_valid_o),
		.tape_end_o    (tape_end_o),
		.load_done_o   (load_done_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ========================================================================
	// Error handling
	// ========================================================================
	task automatic stop_on_error(input string what);
		fail_count++;
		$display("%s", what);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
	                           input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL at %0t: %s expected %0h, got %0h", $time, name, exp, act);
			stop_on_error("value mismatch");
		end
	endtask

	// ========================================================================
	// Test data file
	// ========================================================================
	function automatic int hex_value(input byte c);
		if (c >= "0" && c <= "9") begin
			return c - "0";
		end else if (c >= "a" && c <= "f") begin
			return c - "a" + 10;
		end else if (c >= "A" && c <= "F") begin
			return c - "A" + 10;
		end
		return -1;
	endfunction

	// One 32-bit hex command per line, blanks inside a command are ignored
	task automatic load_commands();
		int          fd;
		int          i;
		int          digits;
		int          count;
		int          nibble;
		logic        comment;
		logic [31:0] rec;
		string       line;
		fd = $fopen("tests/c64_loader_testdata.txt", "r");
		if (fd == 0) stop_on_error("cannot open the test data file");
		count = 0;
		while ($fgets(line, fd) != 0) begin
			rec     = '0;
			digits  = 0;
			comment = 1'b0;
			for (i = 0; i < line.len(); i++) begin
				if (line[i] == "/") begin
					comment = 1'b1;
				end
				nibble = hex_value(line[i]);
				if (!comment && nibble >= 0) begin
					rec = {rec[27:0], nibble[3:0]};
					digits++;
				end
			end
			if (digits == 8) begin
				if (count >= MAX_CMDS) begin
					stop_on_error("too many commands in the test data file");
				end
				cmds[count] = rec;
				count++;
			end else if (digits != 0) begin
				stop_on_error("malformed command line in the test data file");
			end
		end
		$fclose(fd);
		if (count == 0) stop_on_error("the test data file holds no commands");
	endtask

	// ========================================================================
	// Bus helpers
	// ========================================================================
	task automatic check_reset_state();
		@(negedge clk_sys);
		check_value("core_gnt_o", 32'd0, core_gnt_o);
		check_value("core_rvalid_o", 32'd0, core_rvalid_o);
		check_value("dl_wait_o", 32'd0, dl_wait_o);
		check_value("load_done_o", 32'd0, load_done_o);
		check_value("tape_valid_o", 32'd0, tape_valid_o);
		check_value("tape_end_o", 32'd0, tape_end_o);
	endtask

	task automatic core_access(input logic we, input addr_t addr, input byte_t data);
		int n;
		n = 0;
		@(posedge clk_sys);
		core_req_i <= '{req: 1'b1, we: we, addr: addr, data: data};
		@(negedge clk_sys);
		while (!core_gnt_o) begin
			n++;
			if (n > TIMEOUT) stop_on_error("core request was never granted");
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		core_req_i <= '0;
		if (!we) begin
			n = 0;
			@(negedge clk_sys);
			while (!core_rvalid_o) begin
				n++;
				if (n > TIMEOUT) stop_on_error("core read data never arrived");
				@(negedge clk_sys);
			end
			check_value($sformatf("core_rdata_o[%05h]", addr), data, core_rdata_o);
		end
	endtask

	task automatic wait_host_ready();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (dl_wait_o) begin
			n++;
			if (n > TIMEOUT) stop_on_error("dl_wait_o stayed high");
			@(negedge clk_sys);
		end
	endtask

	task automatic download_byte(input dl_kind_e kind, input addr_t addr, input byte_t data);
		// Open the download a cycle ahead of the first strobe
		if (!dl_open || open_kind != kind) begin
			@(posedge clk_sys);
			dl_active_i <= 1'b1;
			dl_kind_i   <= kind;
			dl_open      = 1'b1;
			open_kind    = kind;
			@(posedge clk_sys);
		end
		wait_host_ready();
		@(posedge clk_sys);
		dl_wr_i   <= 1'b1;
		dl_addr_i <= addr;
		dl_data_i <= data;
		@(posedge clk_sys);
		dl_wr_i <= 1'b0;
	endtask

	task automatic download_end();
		wait_host_ready();
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		dl_open      = 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic wait_load_done();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!done_seen) begin
			n++;
			if (n > TIMEOUT) stop_on_error("load_done_o never pulsed after the PRG download");
			@(negedge clk_sys);
		end
		done_seen = 1'b0;
	endtask

	task automatic wait_tape_end();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (expected_tape.size() != 0 || !tape_end_o) begin
			n++;
			if (n > TIMEOUT) stop_on_error("tape playback did not reach its end");
			@(negedge clk_sys);
		end
	endtask

	// ========================================================================
	// Monitors and back-pressure
	// ========================================================================
	always @(posedge clk_sys) begin
		if (reset_n && load_done_o) begin
			done_seen <= 1'b1;
		end
	end

	// Every tape byte must match the next expected one in file order
	always @(posedge clk_sys) begin
		if (reset_n) begin
			if (tape_valid_o) begin
				if (expected_tape.size() == 0) begin
					stop_on_error("tape byte came out when none was expected");
				end else begin
					tape_byte = expected_tape.pop_front();
					check_value("tape_data_o", tape_byte, tape_data_o);
				end
			end
			if (tape_end_o && expected_tape.size() != 0) begin
				stop_on_error("tape_end_o went high before the last tape byte");
			end
		end
	end

	always @(posedge clk_sys) begin
		tape_full_i <= (($random(seed) & 3) == 0);
	end

	// ========================================================================
	// Command replay
	// ========================================================================
	initial begin : replay
		int          idx;
		logic        stop;
		logic [31:0] rec;
		reset_n     = 1'b0;
		dl_active_i = 1'b0;
		dl_kind_i   = DL_OTHER;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = '0;
		core_req_i  = '0;
		tape_play_i = 1'b0;
		tape_full_i = 1'b0;
		for (idx = 0; idx < MAX_CMDS; idx++) cmds[idx] = '0;
		load_commands();

		repeat (3) @(posedge clk_sys);
		reset_n <= 1'b1;
		@(posedge clk_sys);
		check_reset_state();

		stop = 1'b0;
		for (idx = 0; idx < MAX_CMDS && !stop; idx++) begin
			rec = cmds[idx];
			case (rec[31:28])
				4'h0: stop = 1'b1;
				4'h1: core_access(1'b1, rec[25:8], rec[7:0]);
				4'h2: core_access(1'b0, rec[25:8], rec[7:0]);
				4'h3: download_byte(DL_PRG, rec[25:8], rec[7:0]);
				4'h4: download_byte(DL_TAP, rec[25:8], rec[7:0]);
				4'h5: download_end();
				4'h6: expected_tape.push_back(rec[7:0]);
				4'h7: begin
					@(posedge clk_sys);
					tape_play_i <= rec[0];
				end
				4'h8: wait_load_done();
				4'h9: wait_tape_end();
				4'hA: repeat (rec[7:0]) @(posedge clk_sys);
				default: stop_on_error("unknown command in the test data file");
			endcase
		end

		if (fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1);
		end
	end

endmodule

// ==== tests/c64_loader_testdata.txt ====
// One command per line: cmd[31:28] addr[27:8] data[7:0], hex
// 1 core wr, 2 core rd+check, 3 PRG byte, 4 TAP byte, 5 dl end, 6 expected tape byte,
// 7 play level, 8 wait load done, 9 wait tape end, A idle cycles, 0 stop
10002AE1
10003 3E2
100 0ABE3
40000012
40000134
40000256
40000378
4000049A
50000006
A0000014
300000FE
30000108
300002A5
3000035A
300004C3
3000053C
50000004
60000012
60000034
60000056
60000078
6000009A
70000001
2008FEA5
2008FF5A
200900C3
2009013C
22000012
80000000
20002BFE
20002C08
20002D02
20002E09
20002F02
20003009
20003102
20003209
2000ACFE
2000AD08
2000AE02
2000AF09
20002AE1
200033E2
2000ABE3
90000000
70000000
00000000

// ==== list.f ====
src/loader_pkg.sv
src/byte_ram.sv
src/mem_arbiter.sv
src/prg_loader.sv
src/tape_reader.sv
src/c64_loader_top.sv
tests/tb_c64_loader.sv

// ==== Bender.yml ====
package:
  name: c64_loader

sources:
  - src/loader_pkg.sv
  - src/byte_ram.sv
  - src/mem_arbiter.sv
  - src/prg_loader.sv
  - src/tape_reader.sv
  - src/c64_loader_top.sv
  - target: simulation
    files:
      - tests/tb_c64_loader.sv
